//--- hdl/cop_settings.svh
/*
 * Build-time constants of the crypto co-processor.
 * Register file sizes, data widths, instruction field positions and the
 * random-number LFSR constants. Include in every RTL file that needs them.
 */
`ifndef COP_SETTINGS_SVH
`define COP_SETTINGS_SVH

`define COP_XLEN        32              // Data path width
`define COP_NCPR        16              // Number of CPRs
`define COP_CPR_AW      4               // CPR address width
`define COP_GPR_AW      5               // GPR address width
`define COP_BEN_W       4               // Byte enables per word

`define COP_OP_HI       31              // Opcode field
`define COP_OP_LO       28
`define COP_PW_HI       27              // Pack width field
`define COP_PW_LO       26
`define COP_CRD_HI      23              // CPR destination
`define COP_CRD_LO      20
`define COP_CRS1_HI     19              // CPR source 1
`define COP_CRS1_LO     16
`define COP_CRS2_HI     15              // CPR source 2
`define COP_CRS2_LO     12
`define COP_RD_HI       11              // GPR destination
`define COP_RD_LO       7

`define COP_RNG_TAPS    32'hD000_0001   // Right-shift Galois taps
`define COP_RNG_RESET   32'h0000_0001   // LFSR value out of reset

`endif

//--- hdl/cop_pkg.sv
/*
 * Shared types of the crypto co-processor.
 * Opcodes, pack widths, functional unit select, instruction results and
 * the CPU handshake FSM states. Imported by RTL and testbench alike.
 */
package cop_pkg;

    typedef enum logic [3:0] {
        OP_PADD     = 4'h0,     // Packed add
        OP_PSUB     = 4'h1,     // Packed subtract
        OP_AND      = 4'h2,
        OP_OR       = 4'h3,
        OP_XOR      = 4'h4,
        OP_GPR2XCR  = 4'h5,     // GPR rs1 into CPR crd
        OP_XCR2GPR  = 4'h6,     // CPR crs1 into GPR rd
        OP_RSEED    = 4'h7,     // Load LFSR from crs1
        OP_RSAMP    = 4'h8      // Sample LFSR into crd
    } cop_op_e;                 // Codes 9 to 15 are illegal

    typedef enum logic [1:0] {
        PW_32       = 2'b00,
        PW_16       = 2'b01,
        PW_8        = 2'b10
    } cop_pw_e;                 // Code 11 is illegal

    typedef enum logic [1:0] {
        UNIT_NONE   = 2'd0,
        UNIT_PALU   = 2'd1,
        UNIT_RNG    = 2'd2
    } cop_unit_e;

    typedef enum logic [2:0] {
        RES_SUCCESS = 3'd0,
        RES_BAD_INS = 3'd1
    } cop_result_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_WAITING   = 2'd1,
        ST_EXECUTING = 2'd2,
        ST_FINISHED  = 2'd3
    } cop_state_e;

endpackage

//--- hdl/cop_control.sv
/*
 * Issue and writeback stage of the co-processor.
 * Runs the CPU request/acknowledge/response FSM, captures the instruction
 * and rs1 at acceptance and registers the GPR writeback and result when
 * the single execute cycle completes.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_control import cop_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    cpu_insn_req,   // Instruction request
    input  logic [31:0]             cpu_insn_enc,   // Held while requesting
    input  logic [`COP_XLEN-1:0]    cpu_rs1,
    input  logic                    cpu_insn_ack,   // Response taken by CPU
    input  logic                    id_exception,
    input  logic                    id_gpr_wen,
    input  logic [`COP_GPR_AW-1:0]  id_rd,
    input  logic [`COP_XLEN-1:0]    gpr_wdata,      // From PALU
    output logic                    cop_insn_ack,
    output logic                    cop_insn_rsp,
    output logic                    cop_wen,
    output logic [`COP_GPR_AW-1:0]  cop_waddr,
    output logic [`COP_XLEN-1:0]    cop_wdata,
    output cop_result_e             cop_result,
    output logic [31:0]             insn_enc,       // Captured encoding
    output logic [`COP_XLEN-1:0]    gpr_rs1,        // Captured rs1
    output logic                    exec_valid      // Execute cycle
);

    cop_state_e state;
    cop_state_e state_n;
    logic       ack_n;
    logic       rsp_n;
    logic       insn_accept;
    logic       insn_retired;

    assign insn_accept  = cpu_insn_req && cop_insn_ack;
    assign insn_retired = cop_insn_rsp && cpu_insn_ack;
    assign exec_valid   = (state == ST_EXECUTING); // Every unit finishes in one cycle

    always_comb begin
        state_n = state;
        ack_n   = 1'b0;
        rsp_n   = 1'b0;
        case (state)
            ST_IDLE: begin
                state_n = ST_WAITING;
                ack_n   = 1'b1;
            end
            ST_WAITING: begin
                if (insn_accept) begin
                    state_n = ST_EXECUTING; // Ack drops next cycle
                end else begin
                    ack_n   = 1'b1;
                end
            end
            ST_EXECUTING: begin
                state_n = ST_FINISHED;
                rsp_n   = 1'b1;
            end
            ST_FINISHED: begin
                if (insn_retired) begin
                    state_n = ST_WAITING;
                    ack_n   = 1'b1;
                end else begin
                    rsp_n   = 1'b1;             // Hold under back-pressure
                end
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state        <= ST_IDLE;
            cop_insn_ack <= 1'b0;
            cop_insn_rsp <= 1'b0;
            cop_wen      <= 1'b0;
        end else begin
            state        <= state_n;
            cop_insn_ack <= ack_n;
            cop_insn_rsp <= rsp_n;
            if (exec_valid) begin
                cop_wen <= id_gpr_wen;          // Decode keeps this low on exceptions
            end else if (insn_retired) begin
                cop_wen <= 1'b0;                // Strobe only lives with rsp
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (insn_accept) begin
            insn_enc <= cpu_insn_enc;
            gpr_rs1  <= cpu_rs1;
        end
        if (exec_valid) begin
            cop_waddr  <= id_rd;
            cop_wdata  <= gpr_wdata;
            cop_result <= id_exception ? RES_BAD_INS : RES_SUCCESS;
        end
    end

endmodule

//--- hdl/cop_decode.sv
/*
 * Decode and dispatch stage.
 * Splits the captured encoding into fields, picks the functional unit,
 * flags illegal instructions and raises one unit valid in the execute cycle.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_decode import cop_pkg::*; (
    input  logic [31:0]             insn_enc,
    input  logic                    exec_valid,
    output cop_op_e                 op,
    output cop_pw_e                 pw,
    output logic [`COP_CPR_AW-1:0]  crd,
    output logic [`COP_CPR_AW-1:0]  crs1,
    output logic [`COP_CPR_AW-1:0]  crs2,
    output logic [`COP_GPR_AW-1:0]  rd,
    output logic                    palu_ivalid,
    output logic                    rng_ivalid,
    output logic                    id_exception,
    output logic                    id_gpr_wen
);

    cop_unit_e  fu_sel;     // Target functional unit
    logic [1:0] pw_raw;
    logic       pw_bad;     // Reserved pack width on packed arithmetic

    assign op     = cop_op_e'(insn_enc[`COP_OP_HI:`COP_OP_LO]);
    assign pw_raw = insn_enc[`COP_PW_HI:`COP_PW_LO];
    assign pw     = cop_pw_e'(pw_raw);
    assign crd    = insn_enc[`COP_CRD_HI:`COP_CRD_LO];
    assign crs1   = insn_enc[`COP_CRS1_HI:`COP_CRS1_LO];
    assign crs2   = insn_enc[`COP_CRS2_HI:`COP_CRS2_LO];
    assign rd     = insn_enc[`COP_RD_HI:`COP_RD_LO];

    always_comb begin
        case (op)
            OP_PADD, OP_PSUB, OP_AND, OP_OR, OP_XOR,
            OP_GPR2XCR, OP_XCR2GPR: fu_sel = UNIT_PALU;
            OP_RSEED, OP_RSAMP:     fu_sel = UNIT_RNG;
            default:                fu_sel = UNIT_NONE;  // Unassigned opcode
        endcase
    end

    assign pw_bad       = (op == OP_PADD || op == OP_PSUB) && (pw_raw == 2'b11);
    assign id_exception = (fu_sel == UNIT_NONE) || pw_bad;

    // Dispatch only in the execute cycle, and never for a bad instruction
    assign palu_ivalid  = exec_valid && !id_exception && (fu_sel == UNIT_PALU);
    assign rng_ivalid   = exec_valid && !id_exception && (fu_sel == UNIT_RNG);
    assign id_gpr_wen   = (op == OP_XCR2GPR) && !id_exception;

endmodule

//--- hdl/cop_cprs.sv
/*
 * Co-processor register file.
 * Sixteen 32-bit CPRs with two asynchronous read ports and one write port
 * that updates only the bytes selected by its byte enables.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_cprs (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic [`COP_CPR_AW-1:0]  crs1_addr,
    input  logic [`COP_CPR_AW-1:0]  crs2_addr,
    input  logic [`COP_CPR_AW-1:0]  crd_addr,
    input  logic [`COP_BEN_W-1:0]   crd_ben,    // Zero means no write
    input  logic [`COP_XLEN-1:0]    crd_wdata,
    output logic [`COP_XLEN-1:0]    crs1_rdata,
    output logic [`COP_XLEN-1:0]    crs2_rdata
);

    logic [`COP_XLEN-1:0] cprs [`COP_NCPR];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < `COP_NCPR; i++) begin
                cprs[i] <= '0;
            end
        end else begin
            for (int b = 0; b < `COP_BEN_W; b++) begin
                if (crd_ben[b]) begin
                    cprs[crd_addr][8*b +: 8] <= crd_wdata[8*b +: 8];
                end
            end
        end
    end

    assign crs1_rdata = cprs[crs1_addr];    // Read before this cycle's write
    assign crs2_rdata = cprs[crs2_addr];

endmodule

//--- hdl/cop_palu.sv
/*
 * Packed arithmetic, bitwise and move unit.
 * Purely combinational over the CPR read data and the captured GPR rs1.
 * Drives zero on its CPR write bus and GPR data when not selected.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_palu import cop_pkg::*; (
    input  logic                    palu_ivalid,
    input  cop_op_e                 op,
    input  cop_pw_e                 pw,
    input  logic [`COP_XLEN-1:0]    crs1_rdata,
    input  logic [`COP_XLEN-1:0]    crs2_rdata,
    input  logic [`COP_XLEN-1:0]    gpr_rs1,
    output logic [`COP_BEN_W-1:0]   palu_ben,
    output logic [`COP_XLEN-1:0]    palu_wdata,
    output logic [`COP_XLEN-1:0]    gpr_wdata
);

    logic                   sub;
    logic                   carry;          // Ripples between bytes of one lane
    logic                   lane_start;
    logic [8:0]             byte_sum;
    logic [7:0]             byte_b;
    logic [`COP_XLEN-1:0]   arith;

    assign sub = (op == OP_PSUB);

    // Byte-wise ripple, carry restarts at every lane boundary
    always_comb begin
        carry = sub;
        arith = '0;
        for (int b = 0; b < `COP_BEN_W; b++) begin
            case (pw)
                PW_8:    lane_start = 1'b1;
                PW_16:   lane_start = (b % 2 == 0);
                default: lane_start = (b == 0);   // PW_32
            endcase
            if (lane_start) begin
                carry = sub;                     // Two's complement +1 per lane
            end
            byte_b   = sub ? ~crs2_rdata[8*b +: 8] : crs2_rdata[8*b +: 8];
            byte_sum = {1'b0, crs1_rdata[8*b +: 8]} + {1'b0, byte_b} + {8'b0, carry};
            arith[8*b +: 8] = byte_sum[7:0];
            carry    = byte_sum[8];
        end
    end

    always_comb begin
        palu_ben   = '0;
        palu_wdata = '0;
        gpr_wdata  = '0;
        if (palu_ivalid) begin
            case (op)
                OP_PADD, OP_PSUB: begin
                    palu_ben   = '1;
                    palu_wdata = arith;
                end
                OP_AND: begin
                    palu_ben   = '1;
                    palu_wdata = crs1_rdata & crs2_rdata;
                end
                OP_OR: begin
                    palu_ben   = '1;
                    palu_wdata = crs1_rdata | crs2_rdata;
                end
                OP_XOR: begin
                    palu_ben   = '1;
                    palu_wdata = crs1_rdata ^ crs2_rdata;
                end
                OP_GPR2XCR: begin
                    palu_ben   = '1;
                    palu_wdata = gpr_rs1;
                end
                OP_XCR2GPR: gpr_wdata = crs1_rdata;   // No CPR write
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/cop_rng.sv
/*
 * Random-number unit built on a 32-bit Galois LFSR.
 * RSEED loads the state from crs1. RSAMP returns the current state to crd
 * and advances the LFSR by one step on the same edge.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_rng import cop_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    rng_ivalid,
    input  cop_op_e                 op,
    input  logic [`COP_XLEN-1:0]    crs1_rdata,
    output logic [`COP_BEN_W-1:0]   rng_ben,
    output logic [`COP_XLEN-1:0]   rng_wdata
);

    logic [`COP_XLEN-1:0] lfsr;
    logic [`COP_XLEN-1:0] lfsr_step;
    logic                 sample;

    // Shift right, fold the taps back in when a one falls out
    assign lfsr_step = {1'b0, lfsr[`COP_XLEN-1:1]} ^ (lfsr[0] ? `COP_RNG_TAPS : '0);
    assign sample    = rng_ivalid && (op == OP_RSAMP);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            lfsr <= `COP_RNG_RESET;
        end else if (rng_ivalid && op == OP_RSEED) begin
            lfsr <= crs1_rdata;
        end else if (sample) begin
            lfsr <= lfsr_step;
        end
    end

    assign rng_ben   = sample ? '1 : '0;
    assign rng_wdata = sample ? lfsr : '0;  // Value before the step

endmodule

//--- hdl/cop_top.sv
/*
 * Top level of the crypto co-processor.
 * Connects issue/writeback, decode, the CPR file and the two functional
 * units, and merges the unit write buses onto the single CPR write port.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_top import cop_pkg::*; (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    cpu_insn_req,
    input  logic [31:0]             cpu_insn_enc,
    input  logic [`COP_XLEN-1:0]    cpu_rs1,
    input  logic                    cpu_insn_ack,
    output logic                    cop_insn_ack,
    output logic                    cop_insn_rsp,
    output logic                    cop_wen,
    output logic [`COP_GPR_AW-1:0]  cop_waddr,
    output logic [`COP_XLEN-1:0]    cop_wdata,
    output cop_result_e             cop_result
);

    logic [31:0]             insn_enc;      // Captured at acceptance
    logic [`COP_XLEN-1:0]    gpr_rs1;
    logic                    exec_valid;
    cop_op_e                 id_op;
    cop_pw_e                 id_pw;
    logic [`COP_CPR_AW-1:0]  id_crd;
    logic [`COP_CPR_AW-1:0]  id_crs1;
    logic [`COP_CPR_AW-1:0]  id_crs2;
    logic [`COP_GPR_AW-1:0]  id_rd;
    logic                    palu_ivalid;
    logic                    rng_ivalid;
    logic                    id_exception;
    logic                    id_gpr_wen;
    logic [`COP_XLEN-1:0]    crs1_rdata;
    logic [`COP_XLEN-1:0]    crs2_rdata;
    logic [`COP_BEN_W-1:0]   palu_ben;
    logic [`COP_XLEN-1:0]    palu_wdata;
    logic [`COP_BEN_W-1:0]   rng_ben;
    logic [`COP_XLEN-1:0]    rng_wdata;
    logic [`COP_XLEN-1:0]    gpr_wdata;
    logic [`COP_BEN_W-1:0]   crd_ben;
    logic [`COP_XLEN-1:0]    crd_wdata;

    // Idle units drive zero, so OR is enough
    assign crd_ben   = palu_ben | rng_ben;
    assign crd_wdata = palu_wdata | rng_wdata;

    cop_control u_control (
        .g_clk, .g_resetn, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_insn_ack,
        .id_exception, .id_gpr_wen, .id_rd, .gpr_wdata,
        .cop_insn_ack, .cop_insn_rsp, .cop_wen, .cop_waddr, .cop_wdata, .cop_result,
        .insn_enc, .gpr_rs1, .exec_valid
    );

    cop_decode u_decode (
        .insn_enc, .exec_valid,
        .op(id_op), .pw(id_pw), .crd(id_crd), .crs1(id_crs1), .crs2(id_crs2), .rd(id_rd),
        .palu_ivalid, .rng_ivalid, .id_exception, .id_gpr_wen
    );

    cop_cprs u_cprs (
        .g_clk, .g_resetn,
        .crs1_addr(id_crs1), .crs2_addr(id_crs2), .crd_addr(id_crd),
        .crd_ben, .crd_wdata, .crs1_rdata, .crs2_rdata
    );

    cop_palu u_palu (
        .palu_ivalid, .op(id_op), .pw(id_pw), .crs1_rdata, .crs2_rdata, .gpr_rs1,
        .palu_ben, .palu_wdata, .gpr_wdata
    );

    cop_rng u_rng (
        .g_clk, .g_resetn, .rng_ivalid, .op(id_op), .crs1_rdata,
        .rng_ben, .rng_wdata
    );

endmodule

//--- tb/cop_assertions.sv
/*
 * Handshake checks for the co-processor top level.
 * Bound into cop_top and watches the request, acknowledge and response levels.
 */
`timescale 1ns/10ps

module cop_assertions (
    input logic g_clk,
    input logic g_resetn,
    input logic cpu_insn_req,
    input logic cpu_insn_ack,
    input logic cop_insn_ack,
    input logic cop_insn_rsp,
    input logic cop_wen
);

    // One instruction in flight, so never both
    ack_rsp_exclusive: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(cop_insn_ack && cop_insn_rsp))
        else $error("ack and rsp high in the same cycle");

    rsp_held: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_insn_rsp && !cpu_insn_ack |=> cop_insn_rsp)     // Back-pressure
        else $error("rsp dropped before the CPU acknowledged it");

    wen_with_rsp: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cop_wen |-> cop_insn_rsp)
        else $error("GPR write strobe without rsp");

    // Rsp is set on the edge after acceptance, so it is seen high one edge later
    rsp_one_cycle: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cpu_insn_req && cop_insn_ack |=> ##1 $rose(cop_insn_rsp))
        else $error("rsp did not rise one cycle after acceptance");

endmodule

bind cop_top cop_assertions u_cop_assertions (
    .g_clk(g_clk), .g_resetn(g_resetn), .cpu_insn_req(cpu_insn_req),
    .cpu_insn_ack(cpu_insn_ack), .cop_insn_ack(cop_insn_ack),
    .cop_insn_rsp(cop_insn_rsp), .cop_wen(cop_wen)
);

//--- tb/cop_tb.sv
/*
 * Directed testbench for the crypto co-processor.
 * Plays the CPU side of the request/acknowledge/response handshake, keeps
 * its own model of the CPRs and the random unit, and checks every result.
 */
`timescale 1ns/10ps
`include "cop_settings.svh"

module cop_tb import cop_pkg::*; ();

    localparam int          reset_cycles = 8;
    localparam int          insn_count   = 99;          // Issued over all tests
    localparam int          cycle_limit  = 20 * insn_count + reset_cycles;
    localparam logic [31:0] rand_taps    = 32'h8020_0003; // Stimulus LFSR taps

    logic                    g_clk;
    logic                    g_resetn;
    logic                    cpu_insn_req;
    logic [31:0]             cpu_insn_enc;
    logic [`COP_XLEN-1:0]    cpu_rs1;
    logic                    cpu_insn_ack;
    logic                    cop_insn_ack;
    logic                    cop_insn_rsp;
    logic                    cop_wen;
    logic [`COP_GPR_AW-1:0]  cop_waddr;
    logic [`COP_XLEN-1:0]    cop_wdata;
    cop_result_e             cop_result;

    logic [31:0]             rand_state = 32'h3fa0;
    logic [31:0]             cpr_model [`COP_NCPR];  // Expected CPR contents
    logic [31:0]             rng_model;              // Expected LFSR state
    logic                    got_wen;                // Outputs seen with rsp
    logic [`COP_GPR_AW-1:0]  got_waddr;
    logic [31:0]             got_wdata;
    cop_result_e             got_result;
    string                   test_name;
    int                      cycle_count = 0;
    int                      error_count = 0;

    cop_top dut (
        .g_clk, .g_resetn, .cpu_insn_req, .cpu_insn_enc, .cpu_rs1, .cpu_insn_ack,
        .cop_insn_ack, .cop_insn_rsp, .cop_wen, .cop_waddr, .cop_wdata, .cop_result
    );

    always #50 g_clk = ~g_clk;                      // 100 ns period

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            fail_run($sformatf("timeout: run still going after %0d cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string what);
        error_count++;
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s/%s: expected %h, actual %h",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_result(input string what, input cop_result_e exp,
                                input cop_result_e act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s/%s: expected %s, actual %0d",
                               test_name, what, exp.name(), act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("mismatch %s/%s: expected %b, actual %b",
                               test_name, what, exp, act));
        end
    endtask

    // One bit per step, shifted in at the bottom
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            val        = {val[30:0], rand_state[0]};
            rand_state = (rand_state >> 1) ^ (rand_state[0] ? rand_taps : 32'h0);
        end
        return val;
    endfunction

    function automatic logic [31:0] rng_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? `COP_RNG_TAPS : 32'h0);   // Fold taps on a one out
    endfunction

    // Each lane wraps on its own width
    function automatic logic [31:0] lane_model(input logic [31:0] a, input logic [31:0] b,
                                               input int lane_w, input bit sub);
        logic [31:0] mask;
        logic [31:0] la;
        logic [31:0] lb;
        logic [31:0] res;
        mask = (lane_w == 32) ? 32'hffff_ffff : (32'd1 << lane_w) - 32'd1;
        res  = '0;
        for (int lo = 0; lo < 32; lo += lane_w) begin
            la  = (a >> lo) & mask;
            lb  = (b >> lo) & mask;
            res = res | (((sub ? la - lb : la + lb) & mask) << lo);
        end
        return res;
    endfunction

    function automatic logic [31:0] make_enc(input logic [3:0] opc, input logic [1:0] pw,
                                             input int crd, input int crs1,
                                             input int crs2, input int rd);
        logic [31:0] enc;
        enc = '0;
        enc[`COP_OP_HI:`COP_OP_LO]     = opc;
        enc[`COP_PW_HI:`COP_PW_LO]     = pw;
        enc[`COP_CRD_HI:`COP_CRD_LO]   = crd[3:0];
        enc[`COP_CRS1_HI:`COP_CRS1_LO] = crs1[3:0];
        enc[`COP_CRS2_HI:`COP_CRS2_LO] = crs2[3:0];
        enc[`COP_RD_HI:`COP_RD_LO]     = rd[4:0];
        return enc;
    endfunction

    task automatic next_cycle();
        @(posedge g_clk);
        #1;                                         // Drive and sample point
    endtask

    // Request, accept, hold the response for hold cycles, then retire
    task automatic issue_insn(input logic [31:0] enc, input logic [31:0] rs1, input int hold);
        cpu_insn_req = 1'b1;
        cpu_insn_enc = enc;
        cpu_rs1      = rs1;
        while (!cop_insn_ack) begin
            next_cycle();
        end
        next_cycle();                               // Acceptance edge
        cpu_insn_req = 1'b0;
        check_bit("ack after accept", 1'b0, cop_insn_ack);
        next_cycle();
        check_bit("rsp latency", 1'b1, cop_insn_rsp);
        got_wen    = cop_wen;
        got_waddr  = cop_waddr;
        got_wdata  = cop_wdata;
        got_result = cop_result;
        repeat (hold) begin
            next_cycle();
            check_bit("rsp held", 1'b1, cop_insn_rsp);
            check_bit("wen held", got_wen, cop_wen);
            check_data("waddr held", 32'(got_waddr), 32'(cop_waddr));
            check_data("wdata held", got_wdata, cop_wdata);
            check_result("result held", got_result, cop_result);
        end
        cpu_insn_ack = 1'b1;
        next_cycle();                               // Retiring edge
        cpu_insn_ack = 1'b0;
        check_bit("rsp after retire", 1'b0, cop_insn_rsp);
        check_bit("wen after retire", 1'b0, cop_wen);
    endtask

    task automatic write_cpr(input int idx, input logic [31:0] value);
        issue_insn(make_enc(OP_GPR2XCR, PW_32, idx, 0, 0, 0), value, 0);
        cpr_model[idx] = value;
        check_result("gpr2xcr result", RES_SUCCESS, got_result);
        check_bit("gpr2xcr wen", 1'b0, got_wen);
    endtask

    task automatic read_back(input int idx, input int hold);
        logic [4:0] rd;
        rd = 5'(rand_bits(5));                      // Any GPR target
        issue_insn(make_enc(OP_XCR2GPR, PW_32, 0, idx, 0, int'(rd)), 32'h0, hold);
        check_bit("xcr2gpr wen", 1'b1, got_wen);
        check_data("xcr2gpr waddr", 32'(rd), 32'(got_waddr));
        check_data($sformatf("cpr %0d", idx), cpr_model[idx], got_wdata);
        check_result("xcr2gpr result", RES_SUCCESS, got_result);
    endtask

    task automatic test_reset();
        test_name = "reset";
        g_resetn  = 1'b0;
        for (int i = 0; i < `COP_NCPR; i++) begin
            cpr_model[i] = '0;
        end
        rng_model = `COP_RNG_RESET;
        repeat (reset_cycles) begin
            next_cycle();
            check_bit("ack in reset", 1'b0, cop_insn_ack);
            check_bit("rsp in reset", 1'b0, cop_insn_rsp);
            check_bit("wen in reset", 1'b0, cop_wen);
        end
        g_resetn = 1'b1;
        next_cycle();
        check_bit("ack after reset", 1'b1, cop_insn_ack);   // IDLE to WAITING
        check_bit("rsp after reset", 1'b0, cop_insn_rsp);
        check_bit("wen after reset", 1'b0, cop_wen);
    endtask

    task automatic test_move();
        test_name = "move";
        for (int i = 0; i < `COP_NCPR; i++) begin
            write_cpr(i, rand_bits(32));
        end
        for (int i = 0; i < `COP_NCPR; i++) begin
            read_back(i, 0);
        end
    endtask

    task automatic test_packed();
        cop_pw_e     pws [3]    = '{PW_32, PW_16, PW_8};
        int          widths [3] = '{32, 16, 8};
        logic [31:0] a;
        logic [31:0] b;
        test_name = "packed";
        for (int w = 0; w < 3; w++) begin
            for (int s = 0; s < 2; s++) begin
                a = rand_bits(32);
                b = rand_bits(32);
                write_cpr(1, a);
                write_cpr(2, b);
                issue_insn(make_enc(s == 1 ? OP_PSUB : OP_PADD, pws[w], 3, 1, 2, 0), 32'h0, 0);
                cpr_model[3] = lane_model(a, b, widths[w], s == 1);
                check_result("packed result", RES_SUCCESS, got_result);
                check_bit("packed wen", 1'b0, got_wen);
                read_back(3, 0);
            end
        end
    endtask

    task automatic test_bitwise();
        cop_op_e     ops [3] = '{OP_AND, OP_OR, OP_XOR};
        logic [31:0] a;
        logic [31:0] b;
        test_name = "bitwise";
        for (int i = 0; i < 3; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            write_cpr(4, a);
            write_cpr(9, b);
            issue_insn(make_enc(ops[i], PW_32, 10, 4, 9, 0), 32'h0, 0);
            case (ops[i])
                OP_AND:  cpr_model[10] = a & b;
                OP_OR:   cpr_model[10] = a | b;
                default: cpr_model[10] = a ^ b;
            endcase
            check_result("bitwise result", RES_SUCCESS, got_result);
            check_bit("bitwise wen", 1'b0, got_wen);    // No GPR write
            read_back(10, 0);
        end
    endtask

    task automatic sample_rng(input int crd);
        issue_insn(make_enc(OP_RSAMP, PW_32, crd, 0, 0, 0), 32'h0, 0);
        cpr_model[crd] = rng_model;                 // State before the step
        rng_model      = rng_next(rng_model);
        check_result("rsamp result", RES_SUCCESS, got_result);
        check_bit("rsamp wen", 1'b0, got_wen);
        read_back(crd, 0);
    endtask

    task automatic test_rng();
        test_name = "rng from reset";
        repeat (4) begin
            sample_rng(7);
        end
        test_name = "rng seeded";
        write_cpr(8, 32'h1357_9bdf);
        issue_insn(make_enc(OP_RSEED, PW_32, 0, 8, 0, 0), 32'h0, 0);
        rng_model = 32'h1357_9bdf;
        check_result("rseed result", RES_SUCCESS, got_result);
        check_bit("rseed wen", 1'b0, got_wen);
        repeat (4) begin
            sample_rng(7);
        end
    endtask

    task automatic test_bad_insn();
        test_name = "bad insn";
        write_cpr(5, rand_bits(32));
        issue_insn(make_enc(4'hc, 2'b00, 5, 5, 5, 1), rand_bits(32), 0); // Unassigned opcode
        check_result("illegal opcode", RES_BAD_INS, got_result);
        check_bit("illegal opcode wen", 1'b0, got_wen);
        read_back(5, 0);                            // CPR 5 untouched
        issue_insn(make_enc(OP_PADD, 2'b11, 5, 5, 5, 1), 32'h0, 0);
        check_result("reserved pw", RES_BAD_INS, got_result);
        check_bit("reserved pw wen", 1'b0, got_wen);
        read_back(5, 0);
        test_name = "back-pressure";
        for (int i = 0; i < 8; i++) begin
            read_back(2 * i, int'(rand_bits(3)));   // Ack held off 0 to 7 cycles
        end
    endtask

    initial begin
        g_clk        = 1'b0;
        g_resetn     = 1'b0;
        cpu_insn_req = 1'b0;
        cpu_insn_enc = '0;
        cpu_rs1      = '0;
        cpu_insn_ack = 1'b0;
        test_reset();
        test_move();
        test_packed();
        test_bitwise();
        test_rng();
        test_bad_insn();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+hdl
hdl/cop_pkg.sv
hdl/cop_control.sv
hdl/cop_decode.sv
hdl/cop_cprs.sv
hdl/cop_palu.sv
hdl/cop_rng.sv
hdl/cop_top.sv
tb/cop_assertions.sv
tb/cop_tb.sv

//--- Makefile
# Verilator build and run of the co-processor testbench
VERILATOR ?= verilator
TOP       ?= cop_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/10ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
RUN_ARGS  ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
